/* tb.f */
common/texEnvPkg.sv
common/mixOperandsIf.sv
texEnv/ArgumentSelect.sv
texEnv/CombineLane.sv
texEnv/MixLane.sv
texEnv/TexEnv.sv
tb/texEnv_assert.sv
tb/TexEnvTb.sv

/* run.sh */
#!/bin/sh
# Build and run the texture combiner testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module TexEnvTb -f tb.f \
    && ./obj_dir/VTexEnvTb | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* tb/TexEnvTb.sv */
// ****************************************
// Texture combiner testbench
// Directed table, seeded random entries,
// reference model and pixel compare
// ****************************************

`timescale 1ns/1ps

module TexEnvTb;

    localparam int TableLength = 14;
    localparam int RandomCount = 40;
    localparam int ResetCycles = 16;
    // Reset, one cycle per entry, two drain cycles and slack
    localparam int CycleLimit = ResetCycles + TableLength + RandomCount + 16;

    localparam texEnvPkg::pixel_t TexDefault = 32'h11223344;
    localparam texEnvPkg::pixel_t EnvDefault = 32'hC08040F0;
    localparam texEnvPkg::pixel_t EnvWhite = 32'hFFFFFFFF;
    localparam texEnvPkg::pixel_t PrimaryDefault = 32'h050A0F14;
    localparam texEnvPkg::pixel_t PreviousDefault = 32'hFFE01080;

    typedef struct packed
    {
        texEnvPkg::source_t       srcRgb;
        texEnvPkg::rgbOperand_t   operandRgb;
        texEnvPkg::source_t       srcAlpha;
        texEnvPkg::alphaOperand_t operandAlpha;
    } argConfig_t;

    typedef struct packed
    {
        texEnvPkg::combine_t combineRgb;
        texEnvPkg::combine_t combineAlpha;
        argConfig_t [2:0]    args;
        texEnvPkg::pixel_t   previousColor;
        texEnvPkg::pixel_t   texColor;
        texEnvPkg::pixel_t   primaryColor;
        texEnvPkg::pixel_t   envColor;
    } stimulus_t;

    logic aclk;
    logic reset;
    stimulus_t drive;
    texEnvPkg::pixel_t color;

    stimulus_t stimulusTable [TableLength];
    texEnvPkg::pixel_t expectedTable [TableLength];
    texEnvPkg::pixel_t expectedQueue [$];
    stimulus_t randomStimulus;
    argConfig_t texArg;
    argConfig_t envArg;
    argConfig_t priArg;
    argConfig_t prevArg;
    integer seed;
    int rowCount = 0;
    int checkedCount = 0;
    int cycleCount = 0;

    TexEnv DUT
    (
        .aclk(aclk),
        .reset(reset),
        .combineRgb(drive.combineRgb),
        .combineAlpha(drive.combineAlpha),
        .srcRgb0(drive.args[0].srcRgb),
        .srcRgb1(drive.args[1].srcRgb),
        .srcRgb2(drive.args[2].srcRgb),
        .srcAlpha0(drive.args[0].srcAlpha),
        .srcAlpha1(drive.args[1].srcAlpha),
        .srcAlpha2(drive.args[2].srcAlpha),
        .operandRgb0(drive.args[0].operandRgb),
        .operandRgb1(drive.args[1].operandRgb),
        .operandRgb2(drive.args[2].operandRgb),
        .operandAlpha0(drive.args[0].operandAlpha),
        .operandAlpha1(drive.args[1].operandAlpha),
        .operandAlpha2(drive.args[2].operandAlpha),
        .previousColor(drive.previousColor),
        .texSrcColor(drive.texColor),
        .primaryColor(drive.primaryColor),
        .envColor(drive.envColor),
        .color(color)
    );

    initial
    begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == CycleLimit)
        begin
            $display("Timeout after %0d cycles, the test did not finish", CycleLimit);
            $display("Some tests failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    function automatic argConfig_t argSel(
        input texEnvPkg::source_t       srcRgb,
        input texEnvPkg::rgbOperand_t   operandRgb,
        input texEnvPkg::source_t       srcAlpha,
        input texEnvPkg::alphaOperand_t operandAlpha
    );
        return '{srcRgb, operandRgb, srcAlpha, operandAlpha};
    endfunction

    function automatic texEnvPkg::pixel_t pickColor(
        input stimulus_t          s,
        input texEnvPkg::source_t src
    );
        texEnvPkg::pixel_t picked;
        case (src)
            texEnvPkg::SrcTexture:  picked = s.texColor;
            texEnvPkg::SrcConstant: picked = s.envColor;
            texEnvPkg::SrcPrimary:  picked = s.primaryColor;
            default:                picked = s.previousColor;
        endcase
        return picked;
    endfunction

    // Alpha sits in the low byte, channel 0
    function automatic texEnvPkg::pixel_t modelArgument(
        input stimulus_t  s,
        input argConfig_t cfg
    );
        texEnvPkg::pixel_t rgbPick;
        texEnvPkg::pixel_t alphaPick;
        texEnvPkg::pixel_t arg;
        rgbPick = pickColor(s, cfg.srcRgb);
        alphaPick = pickColor(s, cfg.srcAlpha);
        for (int ch = 1; ch < 4; ch++)
        begin
            case (cfg.operandRgb)
                texEnvPkg::RgbSrcAlpha:         arg[ch] = rgbPick[0];
                texEnvPkg::RgbOneMinusSrcAlpha: arg[ch] = 8'hFF - rgbPick[0];
                texEnvPkg::RgbSrcColor:         arg[ch] = rgbPick[ch];
                default:                        arg[ch] = 8'hFF - rgbPick[ch];
            endcase
        end
        if (cfg.operandAlpha == texEnvPkg::AlphaOneMinusSrcAlpha)
            arg[0] = 8'hFF - alphaPick[0];
        else
            arg[0] = alphaPick[0];
        return arg;
    endfunction

    function automatic int scaledProduct(input int x, input int y);
        return (x * y + x) >> 8;
    endfunction

    function automatic texEnvPkg::subPixel_t modelLane(
        input texEnvPkg::combine_t  mode,
        input texEnvPkg::subPixel_t a0,
        input texEnvPkg::subPixel_t a1,
        input texEnvPkg::subPixel_t a2
    );
        int x0;
        int x1;
        int x2;
        int value;
        x0 = int'(a0);
        x1 = int'(a1);
        x2 = int'(a2);
        // Scaling by 255 is exact, so ADD and friends reduce to plain sums
        case (mode)
            texEnvPkg::Modulate:    value = scaledProduct(x0, x1);
            texEnvPkg::Add:         value = x0 + x1;
            texEnvPkg::AddSigned:   value = x0 + x1 - 128;
            texEnvPkg::Interpolate: value = scaledProduct(x0, x2) + scaledProduct(x1, 255 - x2);
            texEnvPkg::Subtract:    value = x0 - x1;
            default:                value = x0;
        endcase
        if (value < 0)
            value = 0;
        else if (value > 255)
            value = 255;
        return texEnvPkg::subPixel_t'(value);
    endfunction

    function automatic texEnvPkg::pixel_t modelPixel(input stimulus_t s);
        texEnvPkg::pixel_t arg0;
        texEnvPkg::pixel_t arg1;
        texEnvPkg::pixel_t arg2;
        texEnvPkg::pixel_t result;
        arg0 = modelArgument(s, s.args[0]);
        arg1 = modelArgument(s, s.args[1]);
        arg2 = modelArgument(s, s.args[2]);
        result[0] = modelLane(s.combineAlpha, arg0[0], arg1[0], arg2[0]);
        for (int ch = 1; ch < 4; ch++)
            result[ch] = modelLane(s.combineRgb, arg0[ch], arg1[ch], arg2[ch]);
        return result;
    endfunction

    task automatic checkPixel(input texEnvPkg::pixel_t actual, input texEnvPkg::pixel_t expected);
        if (actual !== expected)
        begin
            $display("Mismatch at time %0t: pixel %0d is %h, expected %h",
                $time, checkedCount, actual, expected);
            $display("Some tests failed");
            $fatal(1, "Stopped at the first wrong pixel");
        end
        else
            checkedCount++;
    endtask

    // Pixel leaving the pipeline now was driven two falling edges ago
    task automatic stepEntry(input stimulus_t s, input texEnvPkg::pixel_t expected);
        if (expectedQueue.size() == 2)
            checkPixel(color, expectedQueue.pop_front());
        else
            checkPixel(color, '0);
        drive = s;
        expectedQueue.push_back(expected);
    endtask

    task automatic addRow(
        input texEnvPkg::combine_t rgbMode,
        input texEnvPkg::combine_t alphaMode,
        input argConfig_t          arg0,
        input argConfig_t          arg1,
        input argConfig_t          arg2,
        input texEnvPkg::pixel_t   env,
        input texEnvPkg::pixel_t   expected
    );
        stimulus_t s;
        s.combineRgb = rgbMode;
        s.combineAlpha = alphaMode;
        s.args = {arg2, arg1, arg0};
        s.previousColor = PreviousDefault;
        s.texColor = TexDefault;
        s.primaryColor = PrimaryDefault;
        s.envColor = env;
        stimulusTable[rowCount] = s;
        expectedTable[rowCount] = expected;
        rowCount++;
    endtask

    task automatic makeRandom(output stimulus_t s);
        // Modes 0 to 5 only
        s.combineRgb = texEnvPkg::combine_t'(3'($unsigned($random(seed)) % 6));
        s.combineAlpha = texEnvPkg::combine_t'(3'($unsigned($random(seed)) % 6));
        for (int k = 0; k < 3; k++)
            s.args[k] = argConfig_t'(7'($random(seed)));
        s.previousColor = $random(seed);
        s.texColor = $random(seed);
        s.primaryColor = $random(seed);
        s.envColor = $random(seed);
    endtask

    initial
    begin
        seed = 34999;
        reset = 1'b1;
        texArg = argSel(texEnvPkg::SrcTexture, texEnvPkg::RgbSrcColor,
            texEnvPkg::SrcTexture, texEnvPkg::AlphaSrcAlpha);
        envArg = argSel(texEnvPkg::SrcConstant, texEnvPkg::RgbSrcColor,
            texEnvPkg::SrcConstant, texEnvPkg::AlphaSrcAlpha);
        priArg = argSel(texEnvPkg::SrcPrimary, texEnvPkg::RgbSrcColor,
            texEnvPkg::SrcPrimary, texEnvPkg::AlphaSrcAlpha);
        prevArg = argSel(texEnvPkg::SrcPrevious, texEnvPkg::RgbSrcColor,
            texEnvPkg::SrcPrevious, texEnvPkg::AlphaSrcAlpha);

        // Sources and operands through REPLACE
        addRow(texEnvPkg::Replace, texEnvPkg::Replace, texArg, texArg, texArg,
            EnvDefault, 32'h11223344);
        addRow(texEnvPkg::Replace, texEnvPkg::Replace, argSel(texEnvPkg::SrcConstant,
            texEnvPkg::RgbOneMinusSrcColor, texEnvPkg::SrcConstant,
            texEnvPkg::AlphaOneMinusSrcAlpha), texArg, texArg, EnvDefault, 32'h3F7FBF0F);
        addRow(texEnvPkg::Replace, texEnvPkg::Replace, argSel(texEnvPkg::SrcPrimary,
            texEnvPkg::RgbSrcAlpha, texEnvPkg::SrcPrimary, texEnvPkg::AlphaSrcAlpha),
            texArg, texArg, EnvDefault, 32'h14141414);
        addRow(texEnvPkg::Replace, texEnvPkg::Replace, argSel(texEnvPkg::SrcPrevious,
            texEnvPkg::RgbOneMinusSrcAlpha, texEnvPkg::SrcTexture,
            texEnvPkg::AlphaOneMinusSrcAlpha), texArg, texArg, EnvDefault, 32'h7F7F7FBB);
        // Products, exact at 1.0
        addRow(texEnvPkg::Modulate, texEnvPkg::Modulate, texArg, envArg, texArg,
            EnvDefault, 32'h0C110C40);
        addRow(texEnvPkg::Modulate, texEnvPkg::Modulate, texArg, envArg, texArg,
            EnvWhite, 32'h11223344);
        addRow(texEnvPkg::Interpolate, texEnvPkg::Interpolate, texArg, priArg, envArg,
            EnvWhite, 32'h11223344);
        addRow(texEnvPkg::Interpolate, texEnvPkg::Interpolate, texArg, prevArg, envArg,
            EnvDefault, 32'h4B811848);
        // Saturation and clamping
        addRow(texEnvPkg::Add, texEnvPkg::Add, texArg, prevArg, texArg,
            EnvDefault, 32'hFFFF43C4);
        addRow(texEnvPkg::Subtract, texEnvPkg::Subtract, texArg, prevArg, texArg,
            EnvDefault, 32'h00002300);
        addRow(texEnvPkg::AddSigned, texEnvPkg::AddSigned, texArg, prevArg, texArg,
            EnvDefault, 32'h90820044);
        addRow(texEnvPkg::AddSigned, texEnvPkg::AddSigned, prevArg, prevArg, texArg,
            EnvDefault, 32'hFFFF0080);
        // Independent RGB and alpha modes, then the reserved DOT3 codes
        addRow(texEnvPkg::Subtract, texEnvPkg::Modulate, prevArg, texArg, texArg,
            EnvDefault, 32'hEEBE0022);
        addRow(texEnvPkg::Dot3Rgb, texEnvPkg::Dot3Rgba, texArg, prevArg, envArg,
            EnvDefault, 32'h11223344);

        drive = stimulusTable[0];
        repeat (ResetCycles) @(negedge aclk);
        reset = 1'b0;

        for (int i = 0; i < TableLength; i++)
        begin
            stepEntry(stimulusTable[i], expectedTable[i]);
            @(negedge aclk);
        end
        for (int i = 0; i < RandomCount; i++)
        begin
            makeRandom(randomStimulus);
            stepEntry(randomStimulus, modelPixel(randomStimulus));
            @(negedge aclk);
        end
        while (expectedQueue.size() > 0)
        begin
            checkPixel(color, expectedQueue.pop_front());
            @(negedge aclk);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* tb/texEnv_assert.sv */
// ****************************************
// Mixer lane assertions, bound into
// every MixLane instance
// ****************************************

`timescale 1ns/1ps

module MixLaneAssert
(
    input logic                 aclk,
    input logic                 reset,
    input logic                 subtractQ,
    input texEnvPkg::subPixel_t biasQ,
    input texEnvPkg::subPixel_t result
);

    // Only ADD_SIGNED carries a bias
    assert property (@(posedge aclk) disable iff (reset)
        (biasQ == '0) || (biasQ == texEnvPkg::HalfValue))
    else
        $error("Mixer bias %h is neither zero nor one half", biasQ);

    assert property (@(posedge aclk) disable iff (reset) !(subtractQ && (biasQ != '0)))
    else
        $error("Mixer subtract and bias are set together");

    // Both register stages cleared
    assert property (@(posedge aclk) $past(reset, 2) |-> (result == '0))
    else
        $error("Mixer result %h is not zero after reset", result);

endmodule

bind MixLane MixLaneAssert mixLaneAssert
(
    .aclk(aclk),
    .reset(reset),
    .subtractQ(subtractQ),
    .biasQ(biasQ),
    .result(result)
);

/* texEnv/TexEnv.sv */
// ****************************************
// Texture environment combiner top level
// Three argument selects, four combine
// lanes and four two-stage mixers
// ****************************************

`timescale 1ns/1ps

module TexEnv
(
    input  logic                     aclk,
    input  logic                     reset,

    input  texEnvPkg::combine_t      combineRgb,
    input  texEnvPkg::combine_t      combineAlpha,
    input  texEnvPkg::source_t       srcRgb0,
    input  texEnvPkg::source_t       srcRgb1,
    input  texEnvPkg::source_t       srcRgb2,
    input  texEnvPkg::source_t       srcAlpha0,
    input  texEnvPkg::source_t       srcAlpha1,
    input  texEnvPkg::source_t       srcAlpha2,
    input  texEnvPkg::rgbOperand_t   operandRgb0,
    input  texEnvPkg::rgbOperand_t   operandRgb1,
    input  texEnvPkg::rgbOperand_t   operandRgb2,
    input  texEnvPkg::alphaOperand_t operandAlpha0,
    input  texEnvPkg::alphaOperand_t operandAlpha1,
    input  texEnvPkg::alphaOperand_t operandAlpha2,

    // Fragment color or output of the previous stage
    input  texEnvPkg::pixel_t        previousColor,
    // Texture sample
    input  texEnvPkg::pixel_t        texSrcColor,
    // Fragment color
    input  texEnvPkg::pixel_t        primaryColor,
    input  texEnvPkg::pixel_t        envColor,

    // Two cycles after the inputs
    output texEnvPkg::pixel_t        color
);

    texEnvPkg::pixel_t argument0;
    texEnvPkg::pixel_t argument1;
    texEnvPkg::pixel_t argument2;

    ArgumentSelect argSelect0
    (
        .srcRgb(srcRgb0),
        .srcAlpha(srcAlpha0),
        .operandRgb(operandRgb0),
        .operandAlpha(operandAlpha0),
        .texColor(texSrcColor),
        .constColor(envColor),
        .primaryColor(primaryColor),
        .previousColor(previousColor),
        .argument(argument0)
    );

    ArgumentSelect argSelect1
    (
        .srcRgb(srcRgb1),
        .srcAlpha(srcAlpha1),
        .operandRgb(operandRgb1),
        .operandAlpha(operandAlpha1),
        .texColor(texSrcColor),
        .constColor(envColor),
        .primaryColor(primaryColor),
        .previousColor(previousColor),
        .argument(argument1)
    );

    ArgumentSelect argSelect2
    (
        .srcRgb(srcRgb2),
        .srcAlpha(srcAlpha2),
        .operandRgb(operandRgb2),
        .operandAlpha(operandAlpha2),
        .texColor(texSrcColor),
        .constColor(envColor),
        .primaryColor(primaryColor),
        .previousColor(previousColor),
        .argument(argument2)
    );

    // One combine lane and mixer per channel, alpha has its own mode
    for (genvar k = 0; k < texEnvPkg::NumSubPixels; k++)
    begin : lane
        texEnvPkg::combine_t laneMode;
        mixOperandsIf laneOperands ();

        if (k == texEnvPkg::AlphaChannel)
        begin : alphaMode
            assign laneMode = combineAlpha;
        end
        else
        begin : rgbMode
            assign laneMode = combineRgb;
        end

        CombineLane combineLane
        (
            .mode(laneMode),
            .arg0(argument0[k]),
            .arg1(argument1[k]),
            .arg2(argument2[k]),
            .operands(laneOperands)
        );

        MixLane mixLane
        (
            .aclk(aclk),
            .reset(reset),
            .operands(laneOperands),
            .result(color[k])
        );
    end

endmodule

/* texEnv/MixLane.sv */
// ****************************************
// Two-stage multiply-add and clamp
// for one color channel
// ****************************************

`timescale 1ns/1ps

module MixLane
(
    input  logic                 aclk,
    input  logic                 reset,
    mixOperandsIf.mixer          operands,
    output texEnvPkg::subPixel_t result
);

    localparam int ProductWidth = 2 * texEnvPkg::SubPixelWidth;
    // Room for 255 + 255 and for -255 - 128
    localparam int SumWidth = texEnvPkg::SubPixelWidth + 3;

    texEnvPkg::subPixel_t productAb;
    texEnvPkg::subPixel_t productCd;
    logic subtractQ;
    texEnvPkg::subPixel_t biasQ;
    logic signed [SumWidth-1:0] sum;
    texEnvPkg::subPixel_t clamped;

    // (x * y + x) >> 8 keeps x * 1.0 exact
    function automatic texEnvPkg::subPixel_t fixedMul(
        input texEnvPkg::subPixel_t x,
        input texEnvPkg::subPixel_t y
    );
        logic [ProductWidth-1:0] full;
        full = ProductWidth'(x) * ProductWidth'(y) + ProductWidth'(x);
        return full[ProductWidth-1 -: texEnvPkg::SubPixelWidth];
    endfunction

    // Stage one
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            productAb <= '0;
            productCd <= '0;
            subtractQ <= 1'b0;
            biasQ <= '0;
        end
        else
        begin
            productAb <= fixedMul(operands.operandA, operands.operandB);
            productCd <= fixedMul(operands.operandC, operands.operandD);
            subtractQ <= operands.subtract;
            biasQ <= operands.bias;
        end
    end

    always_comb
    begin
        sum = $signed(SumWidth'(productAb)) - $signed(SumWidth'(biasQ));
        if (subtractQ)
            sum = sum - $signed(SumWidth'(productCd));
        else
            sum = sum + $signed(SumWidth'(productCd));

        // Saturate to 0..1.0
        if (sum < 0)
            clamped = '0;
        else if (sum > $signed(SumWidth'(texEnvPkg::OneValue)))
            clamped = texEnvPkg::OneValue;
        else
            clamped = sum[texEnvPkg::SubPixelWidth-1:0];
    end

    // Stage two
    always_ff @(posedge aclk)
    begin
        if (reset)
            result <= '0;
        else
            result <= clamped;
    end

endmodule

/* texEnv/CombineLane.sv */
// ****************************************
// Combine mode decode for one lane
// Maps three arguments onto mixer operands
// ****************************************

`timescale 1ns/1ps

module CombineLane
(
    input texEnvPkg::combine_t  mode,
    input texEnvPkg::subPixel_t arg0,
    input texEnvPkg::subPixel_t arg1,
    input texEnvPkg::subPixel_t arg2,
    mixOperandsIf.setup         operands
);

    always_comb
    begin
        // Plain A*B + C*D unless a mode says otherwise
        operands.subtract = 1'b0;
        operands.bias = '0;

        case (mode)
            texEnvPkg::Modulate:
            begin
                // arg0 * arg1
                operands.operandA = arg0;
                operands.operandB = arg1;
                operands.operandC = '0;
                operands.operandD = '0;
            end
            texEnvPkg::Add:
            begin
                operands.operandA = arg0;
                operands.operandB = texEnvPkg::OneValue;
                operands.operandC = arg1;
                operands.operandD = texEnvPkg::OneValue;
            end
            texEnvPkg::AddSigned:
            begin
                // arg0 + arg1 - 0.5
                operands.operandA = arg0;
                operands.operandB = texEnvPkg::OneValue;
                operands.operandC = arg1;
                operands.operandD = texEnvPkg::OneValue;
                operands.bias = texEnvPkg::HalfValue;
            end
            texEnvPkg::Interpolate:
            begin
                // arg0 * arg2 + arg1 * (1 - arg2)
                operands.operandA = arg0;
                operands.operandB = arg2;
                operands.operandC = arg1;
                operands.operandD = texEnvPkg::OneValue - arg2;
            end
            texEnvPkg::Subtract:
            begin
                operands.operandA = arg0;
                operands.operandB = texEnvPkg::OneValue;
                operands.operandC = arg1;
                operands.operandD = texEnvPkg::OneValue;
                operands.subtract = 1'b1;
            end
            default:
            begin
                // Replace, also taken by the unsupported DOT3 codes
                operands.operandA = arg0;
                operands.operandB = texEnvPkg::OneValue;
                operands.operandC = '0;
                operands.operandD = '0;
            end
        endcase
    end

endmodule

/* texEnv/ArgumentSelect.sv */
// ****************************************
// Combiner argument selection
// Source and operand mux for all channels
// ****************************************

`timescale 1ns/1ps

module ArgumentSelect
(
    input  texEnvPkg::source_t       srcRgb,
    input  texEnvPkg::source_t       srcAlpha,
    input  texEnvPkg::rgbOperand_t   operandRgb,
    input  texEnvPkg::alphaOperand_t operandAlpha,
    input  texEnvPkg::pixel_t        texColor,
    input  texEnvPkg::pixel_t        constColor,
    input  texEnvPkg::pixel_t        primaryColor,
    input  texEnvPkg::pixel_t        previousColor,
    output texEnvPkg::pixel_t        argument
);

    texEnvPkg::pixel_t rgbSource;
    texEnvPkg::pixel_t alphaSource;
    texEnvPkg::subPixel_t rgbSourceAlpha;

    function automatic texEnvPkg::pixel_t pickSource(
        input texEnvPkg::source_t src,
        input texEnvPkg::pixel_t  texPixel,
        input texEnvPkg::pixel_t  constPixel,
        input texEnvPkg::pixel_t  primaryPixel,
        input texEnvPkg::pixel_t  previousPixel
    );
        texEnvPkg::pixel_t picked;
        case (src)
            texEnvPkg::SrcTexture:  picked = texPixel;
            texEnvPkg::SrcConstant: picked = constPixel;
            texEnvPkg::SrcPrimary:  picked = primaryPixel;
            texEnvPkg::SrcPrevious: picked = previousPixel;
        endcase
        return picked;
    endfunction

    // RGB and alpha may come from different sources
    assign rgbSource = pickSource(srcRgb, texColor, constColor, primaryColor, previousColor);
    assign alphaSource = pickSource(srcAlpha, texColor, constColor, primaryColor, previousColor);
    assign rgbSourceAlpha = rgbSource[texEnvPkg::AlphaChannel];

    always_comb
    begin
        for (int ch = 0; ch < texEnvPkg::NumSubPixels; ch++)
        begin
            if (ch == texEnvPkg::AlphaChannel)
            begin
                if (operandAlpha == texEnvPkg::AlphaOneMinusSrcAlpha)
                    argument[ch] = texEnvPkg::OneValue - alphaSource[ch];
                else
                    argument[ch] = alphaSource[ch];
            end
            else
            begin
                case (operandRgb)
                    texEnvPkg::RgbSrcAlpha:         argument[ch] = rgbSourceAlpha;
                    texEnvPkg::RgbOneMinusSrcAlpha: argument[ch] = texEnvPkg::OneValue - rgbSourceAlpha;
                    texEnvPkg::RgbSrcColor:         argument[ch] = rgbSource[ch];
                    texEnvPkg::RgbOneMinusSrcColor: argument[ch] = texEnvPkg::OneValue - rgbSource[ch];
                endcase
            end
        end
    end

endmodule

/* common/mixOperandsIf.sv */
// ****************************************
// Multiply-add operands of one lane
// Driven by the combiner, read by the mixer
// ****************************************

`timescale 1ns/1ps

interface mixOperandsIf;

    // Result is A*B +/- C*D - bias
    texEnvPkg::subPixel_t operandA;
    texEnvPkg::subPixel_t operandB;
    texEnvPkg::subPixel_t operandC;
    texEnvPkg::subPixel_t operandD;
    logic subtract;
    texEnvPkg::subPixel_t bias;

    modport setup
    (
        output operandA, operandB, operandC, operandD, subtract, bias
    );

    modport mixer
    (
        input operandA, operandB, operandC, operandD, subtract, bias
    );

endinterface

/* common/texEnvPkg.sv */
// ****************************************
// Texture combiner shared definitions
// Channel widths, fixed-point constants,
// pixel type and configuration enums
// ****************************************

package texEnvPkg;

    localparam int SubPixelWidth = 8;
    localparam int NumSubPixels = 4;

    typedef logic [SubPixelWidth-1:0] subPixel_t;

    // Red is channel 3 in the top byte, alpha is channel 0 in the low byte
    typedef subPixel_t [NumSubPixels-1:0] pixel_t;

    localparam int AlphaChannel = 0;

    // Fixed-point 1.0 and 0.5
    localparam subPixel_t OneValue = 8'd255;
    localparam subPixel_t HalfValue = 8'd128;

    typedef enum logic [2:0]
    {
        Replace = 3'd0,
        Modulate = 3'd1,
        Add = 3'd2,
        AddSigned = 3'd3,
        Interpolate = 3'd4,
        Subtract = 3'd5,
        // Reserved, handled like Replace
        Dot3Rgb = 3'd6,
        Dot3Rgba = 3'd7
    } combine_t;

    typedef enum logic [1:0]
    {
        SrcTexture = 2'd0,
        SrcConstant = 2'd1,
        SrcPrimary = 2'd2,
        SrcPrevious = 2'd3
    } source_t;

    typedef enum logic [1:0]
    {
        RgbSrcAlpha = 2'd0,
        RgbOneMinusSrcAlpha = 2'd1,
        RgbSrcColor = 2'd2,
        RgbOneMinusSrcColor = 2'd3
    } rgbOperand_t;

    typedef enum logic [0:0]
    {
        AlphaSrcAlpha = 1'b0,
        AlphaOneMinusSrcAlpha = 1'b1
    } alphaOperand_t;

endpackage
